// File: rtl/ing_stats_pkg.sv
// Constants, register map and bus types shared by the ingress statistics CSR block
// Design files refer to these through ing_stats_pkg:: scoped names
package ing_stats_pkg;

    ////////////////////////////////////////
    // Sizes and constants
    ////////////////////////////////////////

    localparam int num_ports      = 4;
    localparam int cntr_width     = 32;
    localparam int data_width     = 32;
    localparam int addr_width     = 4;
    localparam int cntrs_per_port = 5;
    localparam int mtu_bytes      = 2000;
    localparam int data_bytes     = 64;

    // Version 1.0 in the upper half, module ID in the lower half
    localparam logic [data_width-1:0] module_version_id = {8'd1, 8'd0, 16'd10};

    // Data path width, a reserved byte, then the port count in the low byte
    localparam logic [data_width-1:0] params_word =
        {8'd0, 8'(data_bytes), 8'd0, 8'(num_ports)};

    ////////////////////////////////////////
    // Register map and counter indexes
    ////////////////////////////////////////

    typedef enum logic [addr_width-1:0] {
        version_id       = 4'd0,
        params           = 4'd1,
        port_enable_con  = 4'd2,
        port_enable_stat = 4'd3,
        cntrs_sample_con = 4'd4,
        cntrs_read_sel   = 4'd5,
        cntrs_read_data  = 4'd6,
        total_regs       = 4'd7
    } csr_addr_e;

    // Position of each counter inside a port snapshot
    typedef enum logic [7:0] {
        cntr_pkt            = 8'd0,
        cntr_byte           = 8'd1,
        cntr_err            = 8'd2,
        cntr_async_fifo_ovf = 8'd3,
        cntr_buf_ovf        = 8'd4
    } cntr_idx_e;

    ////////////////////////////////////////
    // Bundled signals
    ////////////////////////////////////////

    typedef struct packed {
        logic                  write;
        logic                  read;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
    } csr_req_t;

    typedef struct packed {
        logic                  rvalid;
        logic                  err;
        logic [data_width-1:0] rdata;
    } csr_rsp_t;

    // Profile counts coming from the ingress packet path
    typedef struct packed {
        logic [cntr_width-1:0] pkt_cnt;
        logic [cntr_width-1:0] byte_cnt;
        logic [cntr_width-1:0] err_cnt;
    } prof_cnts_t;

    typedef struct packed {
        logic [num_ports-1:0] async_fifo_overflow;
        logic [num_ports-1:0] buf_overflow;
    } ovf_events_t;

    typedef logic [cntrs_per_port-1:0][cntr_width-1:0] port_cntrs_t;

    typedef struct packed {
        logic [7:0] port;
        logic [7:0] cntr;
    } read_sel_t;

endpackage

// File: rtl/ovf_event_counters.sv
// Counts rising edges of the per-port overflow event lines
// A clear pulse from the snapshot stage restarts a port's counts from zero
`timescale 1ns/1ps

module ovf_event_counters (
    input  logic                                   avmm_clk_ifc,
    input  logic                                   peripheral_sresetn_core,
    input  ing_stats_pkg::ovf_events_t             events,
    input  logic [ing_stats_pkg::num_ports-1:0]    clear,
    // Per port, index 0 counts async FIFO overflows and index 1 buffer overflows
    output logic [ing_stats_pkg::num_ports-1:0][1:0][ing_stats_pkg::cntr_width-1:0] ovf_cnts
);

    // Event kind in the outer index so both kinds share one loop
    logic [1:0][ing_stats_pkg::num_ports-1:0] evt;
    logic [1:0][ing_stats_pkg::num_ports-1:0] evt_d;
    logic [1:0][ing_stats_pkg::num_ports-1:0] evt_rise;

    assign evt      = {events.buf_overflow, events.async_fifo_overflow};
    assign evt_rise = evt & ~evt_d;

    ////////////////////////////////////////
    // Edge history and counters
    ////////////////////////////////////////

    always_ff @(posedge avmm_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            evt_d    <= '0;
            ovf_cnts <= '0;
        end else begin
            evt_d <= evt;
            for (int p = 0; p < ing_stats_pkg::num_ports; p++) begin
                for (int k = 0; k < 2; k++) begin
                    // Clear wins over an event seen at the same edge
                    if (clear[p]) begin
                        ovf_cnts[p][k] <= '0;
                    end else if (evt_rise[k][p]) begin
                        ovf_cnts[p][k] <= ovf_cnts[p][k] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: rtl/cntr_snapshot.sv
// Latches all five counters of a port when its sample control bit rises
// Also pulses the clear line for that port's overflow counters
`timescale 1ns/1ps

module cntr_snapshot (
    input  logic                                   avmm_clk_ifc,
    input  logic                                   peripheral_sresetn_core,
    input  logic [ing_stats_pkg::num_ports-1:0]    sample_con,
    input  ing_stats_pkg::prof_cnts_t [ing_stats_pkg::num_ports-1:0] prof_cnts,
    input  logic [ing_stats_pkg::num_ports-1:0][1:0][ing_stats_pkg::cntr_width-1:0] ovf_cnts,
    output logic [ing_stats_pkg::num_ports-1:0]    clear,
    output ing_stats_pkg::port_cntrs_t [ing_stats_pkg::num_ports-1:0] snapshots
);

    logic [ing_stats_pkg::num_ports-1:0] sample_d;

    // Rising sample bit, used as both latch enable and clear pulse
    assign clear = sample_con & ~sample_d;

    ////////////////////////////////////////
    // Snapshot registers
    ////////////////////////////////////////

    always_ff @(posedge avmm_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            sample_d  <= '0;
            snapshots <= '0;
        end else begin
            sample_d <= sample_con;
            for (int p = 0; p < ing_stats_pkg::num_ports; p++) begin
                if (clear[p]) begin
                    snapshots[p][int'(ing_stats_pkg::cntr_pkt)]  <= prof_cnts[p].pkt_cnt;
                    snapshots[p][int'(ing_stats_pkg::cntr_byte)] <= prof_cnts[p].byte_cnt;
                    snapshots[p][int'(ing_stats_pkg::cntr_err)]  <= prof_cnts[p].err_cnt;
                    // Overflow counts as they stand before this edge clears them
                    snapshots[p][int'(ing_stats_pkg::cntr_async_fifo_ovf)] <= ovf_cnts[p][0];
                    snapshots[p][int'(ing_stats_pkg::cntr_buf_ovf)]        <= ovf_cnts[p][1];
                end
            end
        end
    end

endmodule

// File: rtl/cntr_read_select.sv
// Picks one snapshot counter by port and counter index for the read data register
`timescale 1ns/1ps

module cntr_read_select (
    input  logic                                   avmm_clk_ifc,
    input  logic                                   peripheral_sresetn_core,
    input  ing_stats_pkg::read_sel_t               read_sel,
    input  ing_stats_pkg::port_cntrs_t [ing_stats_pkg::num_ports-1:0] snapshots,
    output logic [ing_stats_pkg::data_width-1:0]   read_word
);

    logic [ing_stats_pkg::cntr_width-1:0] sel_word;

    // Only an in-range selection matches, anything else reads as zero
    always_comb begin
        sel_word = '0;
        for (int p = 0; p < ing_stats_pkg::num_ports; p++) begin
            for (int c = 0; c < ing_stats_pkg::cntrs_per_port; c++) begin
                if (int'(read_sel.port) == p && int'(read_sel.cntr) == c) begin
                    sel_word = snapshots[p][c];
                end
            end
        end
    end

    always_ff @(posedge avmm_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            read_word <= '0;
        end else begin
            read_word <= ing_stats_pkg::data_width'(sel_word);
        end
    end

endmodule

// File: rtl/csr_regs.sv
// Host register bank with write decode, enable status copy and registered read response
// Read data and error flag come back one cycle after the read strobe
`timescale 1ns/1ps

module csr_regs (
    input  logic                                   avmm_clk_ifc,
    input  logic                                   peripheral_sresetn_core,
    input  ing_stats_pkg::csr_req_t                req,
    output ing_stats_pkg::csr_rsp_t                rsp,
    input  logic [ing_stats_pkg::data_width-1:0]   read_word,
    output logic [ing_stats_pkg::num_ports-1:0]    ports_enable,
    output logic [ing_stats_pkg::num_ports-1:0]    sample_con,
    output ing_stats_pkg::read_sel_t               read_sel
);

    ////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////

    logic [ing_stats_pkg::data_width-1:0] port_enable_con_q;
    logic [ing_stats_pkg::num_ports-1:0]  port_enable_stat_q;
    logic [ing_stats_pkg::data_width-1:0] sample_con_q;
    logic [ing_stats_pkg::data_width-1:0] read_sel_q;

    ing_stats_pkg::csr_addr_e             addr_e;
    logic                                 addr_err;
    logic [ing_stats_pkg::data_width-1:0] rd_mux;

    logic                                 rvalid_q;
    logic                                 err_q;
    logic [ing_stats_pkg::data_width-1:0] rdata_q;

    assign addr_e   = ing_stats_pkg::csr_addr_e'(req.addr);
    assign addr_err = (req.addr >= ing_stats_pkg::total_regs);

    always_ff @(posedge avmm_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            // All ports come up enabled
            port_enable_con_q  <= {{(ing_stats_pkg::data_width-ing_stats_pkg::num_ports){1'b0}},
                                   {ing_stats_pkg::num_ports{1'b1}}};
            port_enable_stat_q <= '1;
            sample_con_q       <= '0;
            read_sel_q         <= '0;
        end else begin
            port_enable_stat_q <= port_enable_con_q[ing_stats_pkg::num_ports-1:0];
            if (req.write) begin
                case (addr_e)
                    ing_stats_pkg::port_enable_con:  port_enable_con_q <= req.wdata;
                    ing_stats_pkg::cntrs_sample_con: sample_con_q      <= req.wdata;
                    ing_stats_pkg::cntrs_read_sel:   read_sel_q        <= req.wdata;
                    // Read-only and unmapped words ignore writes
                    default: ;
                endcase
            end
        end
    end

    assign ports_enable = port_enable_con_q[ing_stats_pkg::num_ports-1:0];
    assign sample_con   = sample_con_q[ing_stats_pkg::num_ports-1:0];
    assign read_sel     = read_sel_q[$bits(ing_stats_pkg::read_sel_t)-1:0];

    ////////////////////////////////////////
    // Read path
    ////////////////////////////////////////

    // Unmapped words fall to the default and read as zero
    always_comb begin
        case (addr_e)
            ing_stats_pkg::version_id:       rd_mux = ing_stats_pkg::module_version_id;
            ing_stats_pkg::params:           rd_mux = ing_stats_pkg::params_word;
            ing_stats_pkg::port_enable_con:  rd_mux = port_enable_con_q;
            ing_stats_pkg::port_enable_stat: rd_mux = ing_stats_pkg::data_width'(port_enable_stat_q);
            ing_stats_pkg::cntrs_sample_con: rd_mux = sample_con_q;
            ing_stats_pkg::cntrs_read_sel:   rd_mux = read_sel_q;
            ing_stats_pkg::cntrs_read_data:  rd_mux = read_word;
            default:                         rd_mux = '0;
        endcase
    end

    always_ff @(posedge avmm_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            rvalid_q <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            rvalid_q <= req.read;
            err_q    <= req.read && addr_err;
        end
    end

    // Data only moves on a read strobe
    always_ff @(posedge avmm_clk_ifc) begin
        if (req.read) begin
            rdata_q <= rd_mux;
        end
    end

    assign rsp = '{rvalid: rvalid_q, err: err_q, rdata: rdata_q};

endmodule

// File: rtl/ing_stats_csr_top.sv
// Ingress statistics CSR block for the packet router
// Chains overflow counting, snapshot, read selection and the host register bank
`timescale 1ns/1ps

module ing_stats_csr_top (
    input  logic                                   avmm_clk_ifc,
    input  logic                                   peripheral_sresetn_core,
    input  ing_stats_pkg::csr_req_t                req,
    output ing_stats_pkg::csr_rsp_t                rsp,
    input  ing_stats_pkg::prof_cnts_t [ing_stats_pkg::num_ports-1:0] prof_cnts,
    input  ing_stats_pkg::ovf_events_t             events,
    output logic [ing_stats_pkg::num_ports-1:0]    ports_enable
);

    logic [ing_stats_pkg::num_ports-1:0][1:0][ing_stats_pkg::cntr_width-1:0] ovf_cnts;
    logic [ing_stats_pkg::num_ports-1:0]          cnts_clear;
    ing_stats_pkg::port_cntrs_t [ing_stats_pkg::num_ports-1:0] snapshots;
    logic [ing_stats_pkg::num_ports-1:0]          sample_con;
    ing_stats_pkg::read_sel_t                     read_sel;
    logic [ing_stats_pkg::data_width-1:0]         read_word;

    ////////////////////////////////////////
    // Counter pipeline
    ////////////////////////////////////////

    ovf_event_counters u_ovf_event_counters (
        .avmm_clk_ifc            ( avmm_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .events                  ( events                  ),
        .clear                   ( cnts_clear              ),
        .ovf_cnts                ( ovf_cnts                )
    );

    cntr_snapshot u_cntr_snapshot (
        .avmm_clk_ifc            ( avmm_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .sample_con              ( sample_con              ),
        .prof_cnts               ( prof_cnts               ),
        .ovf_cnts                ( ovf_cnts                ),
        .clear                   ( cnts_clear              ),
        .snapshots               ( snapshots               )
    );

    cntr_read_select u_cntr_read_select (
        .avmm_clk_ifc            ( avmm_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .read_sel                ( read_sel                ),
        .snapshots               ( snapshots               ),
        .read_word               ( read_word               )
    );

    // Host side
    csr_regs u_csr_regs (
        .avmm_clk_ifc            ( avmm_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .req                     ( req                     ),
        .rsp                     ( rsp                     ),
        .read_word               ( read_word               ),
        .ports_enable            ( ports_enable            ),
        .sample_con              ( sample_con              ),
        .read_sel                ( read_sel                )
    );

endmodule

// File: verif/ing_stats_assertions.sv
// Concurrent checks on the host bus and enable outputs of the CSR block
// Bound into ing_stats_csr_top by the testbench
`timescale 1ns/1ps

module ing_stats_assertions (
    input logic                                avmm_clk_ifc,
    input logic                                peripheral_sresetn_core,
    input ing_stats_pkg::csr_req_t             req,
    input ing_stats_pkg::csr_rsp_t             rsp,
    input logic [ing_stats_pkg::num_ports-1:0] ports_enable
);

    // Failure counts, summed for the testbench
    int n_rvalid = 0;
    int n_err = 0;
    int n_enable = 0;
    int n_sel = 0;
    int fail_cnt;

    // Last written read select and cycles since that write
    ing_stats_pkg::read_sel_t sel_q;
    int                       sel_age;
    logic                     sel_oor;

    assign fail_cnt = n_rvalid + n_err + n_enable + n_sel;

    always_ff @(posedge avmm_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            sel_q   <= '0;
            sel_age <= 0;
        end else if (req.write && req.addr == ing_stats_pkg::cntrs_read_sel) begin
            sel_q   <= ing_stats_pkg::read_sel_t'(req.wdata[15:0]);
            sel_age <= 0;
        end else if (sel_age < 8) begin
            sel_age <= sel_age + 1;
        end
    end

    assign sel_oor = (int'(sel_q.port) >= ing_stats_pkg::num_ports) ||
                     (int'(sel_q.cntr) >= ing_stats_pkg::cntrs_per_port);

    ////////////////////////////////////////
    // Bus response
    ////////////////////////////////////////

    a_rvalid: assert property (@(posedge avmm_clk_ifc) disable iff (!peripheral_sresetn_core)
        rsp.rvalid == $past(req.read))
        else begin n_rvalid++; $error("rvalid does not follow the read strobe by one cycle"); end

    // Error only for unmapped words, and then the data is zero
    a_err: assert property (@(posedge avmm_clk_ifc) disable iff (!peripheral_sresetn_core)
        req.read |=> (rsp.err == $past(req.addr >= ing_stats_pkg::total_regs)) &&
                     (!rsp.err || rsp.rdata == '0))
        else begin n_err++; $error("Wrong error flag or nonzero data on an error read"); end

    a_enable: assert property (@(posedge avmm_clk_ifc) disable iff (!peripheral_sresetn_core)
        req.write && req.addr == ing_stats_pkg::port_enable_con |=>
            ports_enable == $past(req.wdata[ing_stats_pkg::num_ports-1:0]))
        else begin n_enable++; $error("ports_enable does not follow port_enable_con"); end

    // Read strobe two or more cycles after the select write sees the settled word
    a_sel_zero: assert property (@(posedge avmm_clk_ifc) disable iff (!peripheral_sresetn_core)
        req.read && req.addr == ing_stats_pkg::cntrs_read_data && sel_oor && sel_age >= 1
            |=> rsp.rdata == '0)
        else begin n_sel++; $error("Out of range read select gave nonzero data"); end

endmodule

// File: verif/ing_stats_tb.sv
// Testbench for the ingress statistics CSR block
// Runs register, enable, sampling and overflow tests and prints a summary line
`timescale 1ns/1ps

module ing_stats_tb;

    localparam int clk_period  = 100;
    // Rough cycle budget of all tests, plus a margin for the watchdog
    localparam int test_cycles = 150;
    localparam int margin      = 50;

    logic                                                  avmm_clk_ifc;
    logic                                                  peripheral_sresetn_core;
    ing_stats_pkg::csr_req_t                               req;
    ing_stats_pkg::csr_rsp_t                               rsp;
    ing_stats_pkg::prof_cnts_t [ing_stats_pkg::num_ports-1:0] prof_cnts;
    ing_stats_pkg::ovf_events_t                            events;
    logic [ing_stats_pkg::num_ports-1:0]                   ports_enable;

    logic [31:0] lcg_state = 32'hde1c_0fd2;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;

    ing_stats_csr_top dut (
        .avmm_clk_ifc            ( avmm_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .req                     ( req                     ),
        .rsp                     ( rsp                     ),
        .prof_cnts               ( prof_cnts               ),
        .events                  ( events                  ),
        .ports_enable            ( ports_enable            )
    );

    bind ing_stats_csr_top ing_stats_assertions u_assertions (
        .avmm_clk_ifc            ( avmm_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .req                     ( req                     ),
        .rsp                     ( rsp                     ),
        .ports_enable            ( ports_enable            )
    );

    initial begin
        avmm_clk_ifc = 1'b0;
        forever #(clk_period / 2) avmm_clk_ifc = ~avmm_clk_ifc;
    end

    initial begin
        #((test_cycles + margin) * clk_period);
        $display("Timeout: tests did not finish within %0d cycles", test_cycles + margin);
        $display("Test FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic step(input int n);
        repeat (n) @(posedge avmm_clk_ifc);
        #1;
    endtask

    task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
        req.write = 1'b1;
        req.addr  = addr;
        req.wdata = data;
        step(1);
        req.write = 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic err);
        int waited;
        req.read = 1'b1;
        req.addr = addr;
        step(1);
        req.read = 1'b0;
        waited = 0;
        while (!rsp.rvalid && waited < 4) begin
            step(1);
            waited++;
        end
        assert (rsp.rvalid) else begin
            $display("No read response for address %0d", addr);
            errors++;
        end
        data = rsp.rdata;
        err  = rsp.err;
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // Select one snapshot counter, wait for the word to settle, then read it
    task automatic read_counter(input int port, input int cntr, output logic [31:0] data);
        logic err;
        bus_write(ing_stats_pkg::cntrs_read_sel, {16'd0, 8'(port), 8'(cntr)});
        step(1);
        bus_read(ing_stats_pkg::cntrs_read_data, data, err);
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        $display("test %s done, %0d errors", name, errors - errs_before);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0] data;
        logic        err;
        logic [31:0] exp_prof [ing_stats_pkg::num_ports][3];
        logic [31:0] en_val;
        int          e0;
        int          fails;
        req = '0;
        prof_cnts = '0;
        events = '0;
        peripheral_sresetn_core = 1'b0;
        repeat (8) @(posedge avmm_clk_ifc);
        #1;
        peripheral_sresetn_core = 1'b1;
        step(1);

        // Version 1.0 over ID 10, then 64 data bytes, a zero byte and 4 ports
        e0 = errors;
        bus_read(ing_stats_pkg::version_id, data, err);
        check_word("version_id", 32'h0100_000a, data);
        bus_read(ing_stats_pkg::params, data, err);
        check_word("params", 32'h0040_0004, data);
        check_word("params err", 32'd0, 32'(err));
        for (int a = 7; a < 16; a++) begin
            bus_read(4'(a), data, err);
            check_word($sformatf("unmapped err %0d", a), 32'd1, 32'(err));
            check_word($sformatf("unmapped data %0d", a), 32'd0, data);
        end
        end_test("fixed_regs", e0);

        e0 = errors;
        check_word("enable after reset", 32'hf, 32'(ports_enable));
        for (int i = 0; i < 2; i++) begin
            en_val = (i == 0) ? (next_rand() & 32'h7) : 32'h9;
            bus_write(ing_stats_pkg::port_enable_con, en_val);
            check_word("ports_enable", en_val, 32'(ports_enable));
            bus_read(ing_stats_pkg::port_enable_con, data, err);
            check_word("port_enable_con", en_val, data);
            step(1);
            bus_read(ing_stats_pkg::port_enable_stat, data, err);
            check_word("port_enable_stat", en_val, data);
        end
        end_test("port_enables", e0);

        e0 = errors;
        for (int p = 0; p < ing_stats_pkg::num_ports; p++) begin
            for (int c = 0; c < 3; c++) begin
                exp_prof[p][c] = next_rand();
            end
            prof_cnts[p].pkt_cnt  = exp_prof[p][0];
            prof_cnts[p].byte_cnt = exp_prof[p][1];
            prof_cnts[p].err_cnt  = exp_prof[p][2];
        end
        bus_write(ing_stats_pkg::cntrs_sample_con, 32'hf);
        step(2);
        for (int p = 0; p < ing_stats_pkg::num_ports; p++) begin
            for (int c = 0; c < 3; c++) begin
                read_counter(p, c, data);
                check_word($sformatf("profile p%0d c%0d", p, c), exp_prof[p][c], data);
            end
        end
        read_counter(ing_stats_pkg::num_ports, 0, data);
        check_word("port out of range", 32'd0, data);
        read_counter(0, ing_stats_pkg::cntrs_per_port, data);
        check_word("counter out of range", 32'd0, data);
        end_test("profile_sampling", e0);

        // Port p sees p+1 pulses on both event lines
        e0 = errors;
        bus_write(ing_stats_pkg::cntrs_sample_con, 32'h0);
        for (int i = 0; i < ing_stats_pkg::num_ports; i++) begin
            for (int p = 0; p < ing_stats_pkg::num_ports; p++) begin
                events.async_fifo_overflow[p] = (p >= i);
                events.buf_overflow[p]        = (p >= i);
            end
            step(1);
            events = '0;
            step(1);
        end
        bus_write(ing_stats_pkg::cntrs_sample_con, 32'hf);
        step(2);
        for (int p = 0; p < ing_stats_pkg::num_ports; p++) begin
            read_counter(p, 3, data);
            check_word($sformatf("async_fifo_ovf p%0d", p), 32'(p + 1), data);
            read_counter(p, 4, data);
            check_word($sformatf("buf_ovf p%0d", p), 32'(p + 1), data);
        end
        end_test("overflow_counting", e0);

        e0 = errors;
        bus_write(ing_stats_pkg::cntrs_sample_con, 32'h0);
        bus_write(ing_stats_pkg::cntrs_sample_con, 32'hf);
        step(2);
        for (int p = 0; p < ing_stats_pkg::num_ports; p++) begin
            read_counter(p, 3, data);
            check_word($sformatf("cleared async_fifo_ovf p%0d", p), 32'd0, data);
            read_counter(p, 4, data);
            check_word($sformatf("cleared buf_ovf p%0d", p), 32'd0, data);
        end
        end_test("clear_on_sample", e0);

        fails = dut.u_assertions.fail_cnt;
        $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, fails);
        if (errors == 0 && fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
rtl/ing_stats_pkg.sv
rtl/ovf_event_counters.sv
rtl/cntr_snapshot.sv
rtl/cntr_read_select.sv
rtl/csr_regs.sv
rtl/ing_stats_csr_top.sv
verif/ing_stats_assertions.sv
verif/ing_stats_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ing_stats_tb -f list.f \
    -o ing_stats_sim > sim.log 2>&1 &&
    ./obj_dir/ing_stats_sim +verilator+error+limit+1000 >> sim.log 2>&1 ||
    echo "Test FAILED" >> sim.log
cat sim.log
! grep -q "Test FAILED" sim.log && grep -q "Test OK" sim.log
